/* verif/rob_cases.txt */
# op a b dest phys reg_write expected, all hex
# op: 0 add, 1 sub, 2 and, 3 xor, 4 mul, 5 divu
0 00000005 00000007 01 10 1 0000000c
1 00000003 00000005 02 11 1 fffffffe
2 f0f0ff00 0ff0f0f0 03 12 1 00f0f000
3 a5a5a5a5 ffff0000 04 13 0 5a5aa5a5
0 ffffffff 00000002 05 14 1 00000001
4 00001234 00005678 06 20 1 06260060
4 ffffffff ffffffff 07 21 1 00000001
4 00010000 00010000 08 22 1 00000000
5 00000064 00000007 09 30 1 0000000e
5 deadbeef 00000000 0a 31 1 ffffffff
5 ffffffff 00000010 0b 32 1 0fffffff
5 000f4240 000003e8 0c 33 1 000003e8
0 00000100 00000001 0d 40 0 00000101
1 00000000 00000001 0e 41 1 ffffffff
3 12345678 87654321 0f 42 1 95511559
4 00000003 00000007 10 50 1 00000015
4 0000ffff 0000ffff 11 51 0 fffe0001
2 ffffffff 13579bdf 12 52 1 13579bdf
5 00000009 00000003 13 53 1 00000003
0 7fffffff 00000001 1f 7f 1 80000000

/* all.f */
logic/rob_pkg.sv
logic/dispatch_ctrl.sv
logic/exec_timer.sv
logic/exec_unit.sv
logic/rob_buffer.sv
logic/rob_core.sv
verif/rob_core_sva.sv
verif/rob_core_tb.sv

/* Makefile */
# Verilator build and run for the reorder-buffer testbench

VERILATOR ?= verilator
TOP       ?= rob_core_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal --timescale 1ns/100ps

PASS_MSG := Simulation finished: PASS
SOURCES  := $(shell grep -v '^+' $(FILELIST))
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The case file is read at run time, relative to this directory
run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/rob_core_tb.sv */
module rob_core_tb
    import rob_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam string       CASE_FILE = "verif/rob_cases.txt";
    localparam logic [31:0] LFSR_SEED = 32'h05ce1ff9;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;  // x^32 + x^22 + x^2 + x + 1

    logic    clk = 1'b0;
    logic    rst;
    logic    disp_req;
    disp_t   disp_op;
    logic    disp_ack;
    logic    commit_valid;
    commit_t commit;

    disp_t           case_op  [$];       // Instructions in file order
    logic [XLEN-1:0] case_val [$];       // Expected committed values
    commit_t         expq     [$];       // Dispatched, not yet committed
    logic [31:0]     lfsr   = LFSR_SEED;
    int              limit  = 300;       // Cycle budget, set from the case count
    int              cycles = 0;

    rob_core i_rob_core (
        .clk          (clk),
        .rst          (rst),
        .disp_req     (disp_req),
        .disp_op      (disp_op),
        .disp_ack     (disp_ack),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    always #50 clk = ~clk;  // 100 ns period

    // Right-shift Galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        abort_run($sformatf("** Error: %s expected %h, got %h", name, want, got));
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] op_r;
        logic [31:0] a_r;
        logic [31:0] b_r;
        logic [31:0] dest_r;
        logic [31:0] phys_r;
        logic [31:0] rw_r;
        logic [31:0] val_r;
        disp_t       d;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            abort_run({"Cannot open the case file ", CASE_FILE});
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                op_r, a_r, b_r, dest_r, phys_r, rw_r, val_r);
                    if (n != 7 || op_r > 32'd5) begin
                        abort_run({"Unreadable line in the case file: ", line});
                    end else begin
                        d.op        = op_e'(op_r[2:0]);
                        d.a         = a_r;
                        d.b         = b_r;
                        d.dest      = dest_r[AREG_W-1:0];
                        d.phys      = phys_r[PREG_W-1:0];
                        d.reg_write = rw_r[0];
                        case_op.push_back(d);
                        case_val.push_back(val_r);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Four-phase transfer, entered and left on a falling edge
    task automatic send_instr(input disp_t op);
        disp_op  = op;
        disp_req = 1'b1;
        @(negedge clk);
        while (!disp_ack) begin
            @(negedge clk);          // Held off by a busy unit or a full buffer
        end
        disp_req = 1'b0;
        @(negedge clk);
        while (disp_ack) begin
            @(negedge clk);
        end
    endtask

    // One pass over the case list, with random idle gaps or back to back
    task automatic play_cases(input bit spaced);
        commit_t    want;
        logic [1:0] gap;             // Idle cycles before the next request
        foreach (case_op[i]) begin
            want.value     = case_val[i];
            want.dest      = case_op[i].dest;
            want.phys      = case_op[i].phys;
            want.reg_write = case_op[i].reg_write;
            expq.push_back(want);
            send_instr(case_op[i]);
            if (spaced) begin
                lfsr   = lfsr_next(lfsr);
                gap[0] = lfsr[0];
                lfsr   = lfsr_next(lfsr);
                gap[1] = lfsr[0];
                repeat (gap) @(negedge clk);
            end
        end
    endtask

    // Driver
    initial begin
        rst      = 1'b1;
        disp_req = 1'b0;
        disp_op  = '0;
        load_cases();
        limit = case_op.size() * 2 * 40 + 300;  // Two passes over the list
        repeat (16) begin
            @(negedge clk);
            assert (!disp_ack && !commit_valid)
                else abort_run("disp_ack or commit_valid went high during reset");
        end
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (!disp_ack && !commit_valid)
                else abort_run("disp_ack or commit_valid went high before any request");
        end
        play_cases(1'b1);
        play_cases(1'b0);            // ALU ops behind a DIVU fill the buffer
        while (expq.size() != 0) begin
            @(negedge clk);          // Drain outstanding commits
        end
        repeat (20) @(negedge clk);  // Room for a stray extra commit
        $display("Simulation finished: PASS");
        $finish;
    end

    // Commit monitor, sampled mid-cycle
    always @(negedge clk) begin
        commit_t want;
        if (!rst && commit_valid) begin
            if (expq.size() == 0) begin
                abort_run("Commit seen with no instruction outstanding");
            end else begin
                want = expq.pop_front();  // Program order
                assert (commit.value === want.value)
                    else report_mismatch("commit.value", want.value, commit.value);
                assert (commit.dest === want.dest)
                    else report_mismatch("commit.dest", 32'(want.dest), 32'(commit.dest));
                assert (commit.phys === want.phys)
                    else report_mismatch("commit.phys", 32'(want.phys), 32'(commit.phys));
                assert (commit.reg_write === want.reg_write)
                    else report_mismatch("commit.reg_write", 32'(want.reg_write),
                                         32'(commit.reg_write));
            end
        end
    end

    // Run budget
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            abort_run($sformatf("Timeout after %0d cycles, commits stopped", cycles));
        end
    end

endmodule

/* verif/rob_core_sva.sv */
module rob_core_sva
    import rob_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  disp_req,
    input disp_t disp_op,
    input logic  disp_ack,
    input logic  commit_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    ack_rise_on_req: assert property (@(posedge clk) disable iff (rst)
        $rose(disp_ack) |-> $past(disp_req))  // Taken at the edge before
        else $error("disp_ack rose with no request pending");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (rst)
        $fell(disp_ack) |-> $past(!disp_req))
        else $error("disp_ack fell while disp_req was still high");

    ack_drop_timely: assert property (@(posedge clk) disable iff (rst)
        disp_ack && !disp_req |=> !disp_ack)  // First edge after release
        else $error("disp_ack held after disp_req dropped");

    op_stable: assert property (@(posedge clk) disable iff (rst)
        disp_req && !disp_ack |=> $stable(disp_op))
        else $error("disp_op changed during a pending request");

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> !commit_valid)
        else $error("commit_valid high during reset");

endmodule

bind rob_core rob_core_sva i_rob_core_sva (
    .clk          (clk),
    .rst          (rst),
    .disp_req     (disp_req),
    .disp_op      (disp_op),
    .disp_ack     (disp_ack),
    .commit_valid (commit_valid)
);

/* logic/rob_core.sv */
module rob_core
    import rob_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    disp_req,
    input  disp_t   disp_op,
    output logic    disp_ack,
    output logic    commit_valid,
    output commit_t commit
);

    logic             alloc_en;
    alloc_t           alloc;
    logic             full;
    logic [IDX_W-1:0] tail_idx;
    logic [2:0]       start;      // Bit per unit_e
    logic [2:0]       unit_busy;
    logic [2:0]       done;
    issue_t           issue;      // Shared by all units
    cmpl_t            cmpl [3];   // Completion port per unit

    dispatch_ctrl i_dispatch_ctrl (
        .clk       (clk),
        .rst       (rst),
        .disp_req  (disp_req),
        .disp_op   (disp_op),
        .disp_ack  (disp_ack),
        .full      (full),
        .tail_idx  (tail_idx),
        .unit_busy (unit_busy),
        .alloc_en  (alloc_en),
        .alloc     (alloc),
        .start     (start),
        .issue     (issue)
    );

    exec_unit #(.LATENCY(ALU_LAT)) i_alu (
        .clk   (clk),
        .rst   (rst),
        .start (start[UNIT_ALU]),
        .issue (issue),
        .busy  (unit_busy[UNIT_ALU]),
        .done  (done[UNIT_ALU]),
        .cmpl  (cmpl[UNIT_ALU])
    );

    exec_unit #(.LATENCY(MUL_LAT)) i_mul (
        .clk   (clk),
        .rst   (rst),
        .start (start[UNIT_MUL]),
        .issue (issue),
        .busy  (unit_busy[UNIT_MUL]),
        .done  (done[UNIT_MUL]),
        .cmpl  (cmpl[UNIT_MUL])
    );

    exec_unit #(.LATENCY(DIV_LAT)) i_div (
        .clk   (clk),
        .rst   (rst),
        .start (start[UNIT_DIV]),
        .issue (issue),
        .busy  (unit_busy[UNIT_DIV]),
        .done  (done[UNIT_DIV]),
        .cmpl  (cmpl[UNIT_DIV])
    );

    rob_buffer i_rob_buffer (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc        (alloc),
        .full         (full),
        .tail_idx     (tail_idx),
        .done         (done),
        .cmpl         (cmpl),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

/* logic/rob_buffer.sv */
module rob_buffer
    import rob_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             alloc_en,     // Claim the tail slot
    input  alloc_t           alloc,
    output logic             full,
    output logic [IDX_W-1:0] tail_idx,
    input  logic [2:0]       done,         // One per completion port
    input  cmpl_t            cmpl [3],
    output logic             commit_valid, // One-cycle retire pulse
    output commit_t          commit
);

    // Pointers carry one extra wrap bit
    logic [IDX_W:0] head;
    logic [IDX_W:0] tail;

    logic [ROB_DEPTH-1:0] valid;   // Slot allocated
    logic [ROB_DEPTH-1:0] ready;   // Result written back
    logic [XLEN-1:0]      value [ROB_DEPTH];
    alloc_t               info  [ROB_DEPTH];

    logic [IDX_W-1:0] head_idx;
    logic             retire;      // Head leaves this cycle

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];

    // Same slot, opposite lap
    assign full = (head[IDX_W] != tail[IDX_W]) && (head_idx == tail_idx);

    assign retire = valid[head_idx] && ready[head_idx];

    // Entry status and pointers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            valid <= '0;
            ready <= '0;
        end else begin
            if (alloc_en) begin
                valid[tail_idx] <= 1'b1;
                ready[tail_idx] <= 1'b0;  // Waits for its unit
                tail            <= tail + 1'b1;
            end
            // Ports never target the same slot
            for (int p = 0; p < 3; p++) begin
                if (done[p]) begin
                    ready[cmpl[p].idx] <= 1'b1;
                end
            end
            if (retire) begin
                valid[head_idx] <= 1'b0;  // Slot free again
                ready[head_idx] <= 1'b0;
                head            <= head + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            info[tail_idx] <= alloc;
        end
        for (int p = 0; p < 3; p++) begin
            if (done[p]) begin
                value[cmpl[p].idx] <= cmpl[p].value;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;  // In order, at most one per cycle
        end
    end

    // Commit record registered from the head slot
    always_ff @(posedge clk) begin
        if (retire) begin
            commit.value     <= value[head_idx];
            commit.dest      <= info[head_idx].dest;
            commit.phys      <= info[head_idx].phys;
            commit.reg_write <= info[head_idx].reg_write;
        end
    end

endmodule

/* logic/exec_unit.sv */
module exec_unit
    import rob_pkg::*;
#(
    parameter int LATENCY = 1
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,  // Take issue this cycle
    input  issue_t issue,
    output logic   busy,
    output logic   done,   // One-cycle completion pulse
    output cmpl_t  cmpl
);

    issue_t          held;    // Operands and slot of the running op
    logic [XLEN-1:0] result;
    logic            expire;  // Timer on its final count

    exec_timer #(
        .LATENCY (LATENCY)
    ) i_exec_timer (
        .clk     (clk),
        .rst     (rst),
        .load    (start),
        .running (busy),
        .expire  (expire)
    );

    // Capture at start, held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            held <= issue;
        end
    end

    always_comb begin
        case (held.op)
            OP_ADD:  result = held.a + held.b;
            OP_SUB:  result = held.a - held.b;  // Wraps modulo 2^32
            OP_AND:  result = held.a & held.b;
            OP_XOR:  result = held.a ^ held.b;
            OP_MUL:  result = held.a * held.b;  // Low half of the product
            OP_DIVU: begin
                if (held.b == '0) begin
                    result = '1;  // Divide by zero gives all ones
                end else begin
                    result = held.a / held.b;
                end
            end
            default: result = '0;
        endcase
    end

    // Result is presented in the expiry cycle
    assign done       = expire;
    assign cmpl.idx   = held.idx;
    assign cmpl.value = result;

endmodule

/* logic/exec_timer.sv */
module exec_timer #(
    parameter int LATENCY = 1  // Cycles from load edge to expiry edge
) (
    input  logic clk,
    input  logic rst,
    input  logic load,     // Start a new count
    output logic running,  // Count in progress
    output logic expire    // Last cycle of the count
);

    localparam int CNT_W = $clog2(LATENCY + 1);

    logic [CNT_W-1:0] count;  // Cycles left

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;  // Stops at zero
        end
    end

    assign running = (count != '0);
    assign expire  = (count == CNT_W'(1));  // Final cycle before idle

endmodule

/* logic/dispatch_ctrl.sv */
module dispatch_ctrl
    import rob_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             disp_req,   // Four-phase request
    input  disp_t            disp_op,    // Held stable while req is high
    output logic             disp_ack,
    input  logic             full,       // No free buffer slot
    input  logic [IDX_W-1:0] tail_idx,   // Slot the next allocation gets
    input  logic [2:0]       unit_busy,  // Indexed by unit_e
    output logic             alloc_en,
    output alloc_t           alloc,
    output logic [2:0]       start,      // One strobe per unit
    output issue_t           issue
);

    typedef enum logic {
        IDLE,
        ACKED
    } state_e;

    state_e state;
    state_e state_nxt;
    unit_e  target;   // Unit selected by the opcode
    logic   accept;   // Instruction taken this cycle

    assign target = unit_of(disp_op.op);

    // Take only from IDLE, with a free slot and an idle unit
    assign accept = (state == IDLE) && disp_req && !full && !unit_busy[target];

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = ACKED;  // Ack rises at the accept edge
                end
            end
            ACKED: begin
                if (!disp_req) begin
                    state_nxt = IDLE;   // Requester released, drop ack
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign disp_ack = (state == ACKED);

    // Allocation record straight from the request
    assign alloc_en        = accept;
    assign alloc.dest      = disp_op.dest;
    assign alloc.phys      = disp_op.phys;
    assign alloc.reg_write = disp_op.reg_write;

    // Start only the selected unit
    assign start = accept ? (3'b001 << target) : 3'b000;

    // Shared issue bus, stamped with the slot being allocated
    assign issue.op  = disp_op.op;
    assign issue.a   = disp_op.a;
    assign issue.b   = disp_op.b;
    assign issue.idx = tail_idx;

endmodule

/* logic/rob_pkg.sv */
package rob_pkg;

    // Datapath and buffer sizes
    localparam int XLEN      = 32;  // Operand and result width
    localparam int ROB_DEPTH = 4;   // Entries in the reorder buffer
    localparam int IDX_W     = 2;   // log2 of ROB_DEPTH
    localparam int AREG_W    = 5;   // Architectural register number
    localparam int PREG_W    = 7;   // Physical register tag

    // Unit latencies in cycles, start edge to done edge
    localparam int ALU_LAT = 1;
    localparam int MUL_LAT = 4;
    localparam int DIV_LAT = 8;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_MUL,
        OP_DIVU
    } op_e;

    // Also the bit position in the start and busy vectors
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    typedef struct packed {
        op_e               op;         // Operation
        logic [XLEN-1:0]   a;          // First operand
        logic [XLEN-1:0]   b;          // Second operand
        logic [AREG_W-1:0] dest;       // Architectural destination
        logic [PREG_W-1:0] phys;       // Physical tag
        logic              reg_write;  // Result goes to a register
    } disp_t;

    typedef struct packed {
        op_e              op;
        logic [XLEN-1:0]  a;
        logic [XLEN-1:0]  b;
        logic [IDX_W-1:0] idx;  // Buffer slot of this instruction
    } issue_t;

    typedef struct packed {
        logic [IDX_W-1:0] idx;
        logic [XLEN-1:0]  value;
    } cmpl_t;

    typedef struct packed {
        logic [XLEN-1:0]   value;
        logic [AREG_W-1:0] dest;
        logic [PREG_W-1:0] phys;
        logic              reg_write;
    } commit_t;

    // Per-entry bookkeeping kept until retirement
    typedef struct packed {
        logic [AREG_W-1:0] dest;
        logic [PREG_W-1:0] phys;
        logic              reg_write;
    } alloc_t;

    // Which unit executes a given opcode
    function automatic unit_e unit_of(op_e op);
        case (op)
            OP_MUL:  return UNIT_MUL;
            OP_DIVU: return UNIT_DIV;
            default: return UNIT_ALU;  // Add, sub, and, xor
        endcase
    endfunction

endpackage
